// ==== filelist.f ====
source/ninjin_pkg.sv
source/ninjin_burst_addr.sv
source/gobou_weight_mem.sv
source/ninjin_s_axi_gobou.sv
source/ninjin_gobou_top.sv
bench/ninjin_gobou_assert.sv
bench/ninjin_gobou_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the weight buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ninjin_gobou_tb \
  -f filelist.f

./obj_dir/Vninjin_gobou_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== bench/ninjin_gobou_tb.sv ====
`timescale 1ns/1ps

module ninjin_gobou_tb;
  import ninjin_pkg::*;

  // all six tests take about 800 cycles, limit leaves wide margin
  localparam int TIMEOUT_CYCLES = 3000;

  logic                    clk;
  logic                    xrst;
  logic [ID_WIDTH-1:0]     awid, bid, arid, rid;
  logic [ADDR_WIDTH-1:0]   awaddr, araddr;
  logic [7:0]              awlen, arlen;
  logic [1:0]              awburst, arburst, bresp, rresp;
  logic                    awvalid, awready, wlast, wvalid, wready, bready, bvalid;
  logic                    arvalid, arready, rready, rvalid, rlast;
  logic [DATA_WIDTH-1:0]   wdata, rdata;
  logic [DATA_WIDTH/8-1:0] wstrb;

  logic [DATA_WIDTH-1:0]   model_mem [MEM_WORDS];
  logic [DATA_WIDTH-1:0]   wbuf [256];
  logic [DATA_WIDTH/8-1:0] sbuf [256];
  string                   test_name;
  int                      cycle;
  int                      check_errors;
  int                      errors_at_start;
  int                      tests_run;
  int                      tests_failed;
  int                      last_w_cycle;
  int                      first_r_cycle;

  ninjin_gobou_top ninjin_gobou_top_inst (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ==================================================
  // reference model and checks
  // ==================================================

  // next beat address from the AXI burst rules
  function automatic logic [ADDR_WIDTH-1:0] next_addr(input logic [ADDR_WIDTH-1:0] a,
                                                      input logic [1:0] burst, input int beats);
    int size;
    int base;
    int nxt;
    size = beats * 4;
    if (burst == BURST_FIXED)
      return a;
    nxt = (int'(a) & ~3) + 4;
    if (burst == BURST_WRAP) begin
      base = (int'(a) / size) * size;
      if (nxt >= base + size)
        nxt = base;
    end
    return ADDR_WIDTH'(nxt);
  endfunction

  task automatic model_write(input logic [ADDR_WIDTH-1:0] a, input logic [31:0] d,
                             input logic [3:0] s);
    for (int b = 0; b < 4; b++) begin
      if (s[b])
        model_mem[a[ADDR_WIDTH-1:LSB]][b*8 +: 8] = d[b*8 +: 8];
    end
  endtask

  function automatic int total_errors();
    return check_errors
         + ninjin_gobou_top_inst.ninjin_s_axi_gobou_inst.ninjin_gobou_assert_inst.fail_count;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      check_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = total_errors();
  endtask

  task automatic report_test();
    int n;
    n = total_errors() - errors_at_start;
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      $display("test %s: %0d errors", test_name, n);
      tests_failed++;
    end
  endtask

  task automatic fill_data(input int beats, input bit full_strobe);
    for (int i = 0; i < beats; i++) begin
      wbuf[i] = $urandom;
      sbuf[i] = full_strobe ? 4'hf : 4'($urandom);
    end
  endtask

  // ==================================================
  // AXI master
  // ==================================================

  task automatic axi_write_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                                 input int beats, input logic [1:0] burst, input int b_delay);
    logic [ADDR_WIDTH-1:0] a;
    a       = addr;
    awid    = id;
    awaddr  = addr;
    awlen   = 8'(beats - 1);
    awburst = burst;
    awvalid = 1'b1;
    do @(negedge clk); while (!awready);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      wdata  = wbuf[i];
      wstrb  = sbuf[i];
      wlast  = (i == beats - 1);
      wvalid = 1'b1;
      do @(negedge clk); while (!wready);
      model_write(a, wbuf[i], sbuf[i]);
      last_w_cycle = cycle;
      @(posedge clk);
      #1;
      a = next_addr(a, burst, beats);
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    // response left waiting with bready low
    repeat (b_delay) begin
      @(posedge clk);
      #1;
    end
    bready = 1'b1;
    do @(negedge clk); while (!bvalid);
    check_value("bid", 32'(id), 32'(bid));
    check_value("bresp", 32'(RESP_OKAY), 32'(bresp));
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                                input int beats, input logic [1:0] burst, input bit stall);
    logic [ADDR_WIDTH-1:0] a;
    a       = addr;
    arid    = id;
    araddr  = addr;
    arlen   = 8'(beats - 1);
    arburst = burst;
    arvalid = 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      if (stall) begin
        rready = 1'b0;
        repeat ($urandom % 5) begin
          @(posedge clk);
          #1;
        end
      end
      rready = 1'b1;
      do @(negedge clk); while (!rvalid);
      if (i == 0)
        first_r_cycle = cycle;
      check_value("rdata", model_mem[a[ADDR_WIDTH-1:LSB]], rdata);
      check_value("rlast", 32'(i == beats - 1), 32'(rlast));
      check_value("rid", 32'(id), 32'(rid));
      check_value("rresp", 32'(RESP_OKAY), 32'(rresp));
      @(posedge clk);
      #1;
      a = next_addr(a, burst, beats);
    end
    rready = 1'b0;
  endtask

  // ==================================================
  // tests
  // ==================================================

  initial begin
    void'($urandom(32'h9c37));
    clk          = 1'b0;
    xrst         = 1'b0;
    awid         = '0;
    awaddr       = '0;
    awlen        = '0;
    awburst      = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wlast        = 1'b0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    arid         = '0;
    araddr       = '0;
    arlen        = '0;
    arburst      = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    cycle        = 0;
    check_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    #1;
    xrst = 1'b1;

    start_test("reset");
    repeat (2) begin
      @(negedge clk);
      check_value("ready/valid", 32'd0, 32'({awready, wready, bvalid, arready, rvalid}));
    end
    @(posedge clk);
    #1;
    report_test();

    // full words first, then byte merges on top
    start_test("incr");
    fill_data(16, 1'b1);
    axi_write_burst(12'h011, 12'h100, 16, BURST_INCR, 0);
    fill_data(16, 1'b0);
    axi_write_burst(12'h012, 12'h100, 16, BURST_INCR, 0);
    axi_read_burst(12'h013, 12'h100, 16, BURST_INCR, 1'b0);
    report_test();

    start_test("fixed");
    fill_data(4, 1'b1);
    axi_write_burst(12'h021, 12'h040, 4, BURST_FIXED, 0);
    axi_read_burst(12'h022, 12'h040, 3, BURST_FIXED, 1'b0);
    report_test();

    start_test("wrap");
    fill_data(8, 1'b1);
    axi_write_burst(12'h031, 12'h200, 8, BURST_INCR, 0);
    axi_read_burst(12'h032, 12'h218, 8, BURST_WRAP, 1'b0);
    report_test();

    // both address channels raised in the same cycle
    start_test("ids");
    fill_data(4, 1'b1);
    fork
      axi_write_burst(12'h5a3, 12'h300, 4, BURST_INCR, 0);
      axi_read_burst(12'h1c7, 12'h300, 4, BURST_INCR, 1'b0);
    join
    assert (last_w_cycle < first_r_cycle)
    else begin
      $display("the read burst started before the write burst had finished");
      check_errors++;
    end
    report_test();

    start_test("backpressure");
    fill_data(8, 1'b0);
    axi_write_burst(12'h061, 12'h120, 8, BURST_INCR, 6);
    axi_read_burst(12'h062, 12'h100, 16, BURST_INCR, 1'b1);
    report_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== bench/ninjin_gobou_assert.sv ====
`timescale 1ns/1ps

module ninjin_gobou_assert
  ( input logic                                clk
  , input logic                                xrst
  , input logic                                awready
  , input logic                                arready
  , input logic                                wready
  , input logic                                bvalid
  , input logic                                bready
  , input logic [ninjin_pkg::ID_WIDTH-1:0]     bid
  , input logic                                rvalid
  , input logic                                rready
  , input logic                                rlast
  , input logic [ninjin_pkg::ID_WIDTH-1:0]     rid
  , input logic [ninjin_pkg::DATA_WIDTH-1:0]   rdata
  , input logic                                mem_we
  , input logic                                wr_busy
  );

  // assertion failures seen so far
  int fail_count = 0;

  // ==================================================
  // response channels hold until taken
  // ==================================================

  b_hold: assert property (@(posedge clk) disable iff (!xrst)
    bvalid && !bready |=> bvalid && $stable(bid))
  else begin
    $error("bvalid dropped or bid changed before bready");
    fail_count++;
  end

  r_hold: assert property (@(posedge clk) disable iff (!xrst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast) && $stable(rid))
  else begin
    $error("rvalid dropped or read beat changed before rready");
    fail_count++;
  end

  // one transaction at a time, on the address and the data channels
  ready_excl: assert property (@(posedge clk) disable iff (!xrst)
    !(awready && arready) && !(wready && rvalid))
  else begin
    $error("write and read channels open together");
    fail_count++;
  end

  we_busy: assert property (@(posedge clk) disable iff (!xrst)
    mem_we |-> wr_busy)
  else begin
    $error("memory written outside a write burst");
    fail_count++;
  end

  // the burst closes with its rlast beat
  rlast_end: assert property (@(posedge clk) disable iff (!xrst)
    rvalid |-> !$past(rvalid && rready && rlast, 2))
  else begin
    $error("read beat returned after the rlast beat");
    fail_count++;
  end

endmodule

bind ninjin_s_axi_gobou ninjin_gobou_assert ninjin_gobou_assert_inst
  ( .clk     (clk)
  , .xrst    (xrst)
  , .awready (awready)
  , .arready (arready)
  , .wready  (wready)
  , .bvalid  (bvalid)
  , .bready  (bready)
  , .bid     (bid)
  , .rvalid  (rvalid)
  , .rready  (rready)
  , .rlast   (rlast)
  , .rid     (rid)
  , .rdata   (rdata)
  , .mem_we  (mem_we)
  , .wr_busy (wr_busy)
  );

// ==== source/ninjin_gobou_top.sv ====
`timescale 1ns/1ps

module ninjin_gobou_top
  ( input  logic                                clk
  , input  logic                                xrst
  // write address
  , input  logic [ninjin_pkg::ID_WIDTH-1:0]     awid
  , input  logic [ninjin_pkg::ADDR_WIDTH-1:0]   awaddr
  , input  logic [7:0]                          awlen
  , input  logic [1:0]                          awburst
  , input  logic                                awvalid
  , output logic                                awready
  // write data
  , input  logic [ninjin_pkg::DATA_WIDTH-1:0]   wdata
  , input  logic [ninjin_pkg::DATA_WIDTH/8-1:0] wstrb
  , input  logic                                wlast
  , input  logic                                wvalid
  , output logic                                wready
  // write response
  , input  logic                                bready
  , output logic                                bvalid
  , output logic [ninjin_pkg::ID_WIDTH-1:0]     bid
  , output logic [1:0]                          bresp
  // read address
  , input  logic [ninjin_pkg::ID_WIDTH-1:0]     arid
  , input  logic [ninjin_pkg::ADDR_WIDTH-1:0]   araddr
  , input  logic [7:0]                          arlen
  , input  logic [1:0]                          arburst
  , input  logic                                arvalid
  , output logic                                arready
  // read data
  , input  logic                                rready
  , output logic                                rvalid
  , output logic [ninjin_pkg::ID_WIDTH-1:0]     rid
  , output logic [ninjin_pkg::DATA_WIDTH-1:0]   rdata
  , output logic [1:0]                          rresp
  , output logic                                rlast
  );
  import ninjin_pkg::*;

  // slave to memory
  logic                      mem_we;
  logic [DATA_WIDTH/8-1:0]   mem_be;
  logic [MEM_ADDR_WIDTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0]     mem_wdata;
  logic [DATA_WIDTH-1:0]     mem_rdata;

  ninjin_s_axi_gobou ninjin_s_axi_gobou_inst
    ( .clk       (clk)
    , .xrst      (xrst)
    , .awid      (awid)
    , .awaddr    (awaddr)
    , .awlen     (awlen)
    , .awburst   (awburst)
    , .awvalid   (awvalid)
    , .awready   (awready)
    , .wdata     (wdata)
    , .wstrb     (wstrb)
    , .wlast     (wlast)
    , .wvalid    (wvalid)
    , .wready    (wready)
    , .bready    (bready)
    , .bvalid    (bvalid)
    , .bid       (bid)
    , .bresp     (bresp)
    , .arid      (arid)
    , .araddr    (araddr)
    , .arlen     (arlen)
    , .arburst   (arburst)
    , .arvalid   (arvalid)
    , .arready   (arready)
    , .rready    (rready)
    , .rvalid    (rvalid)
    , .rid       (rid)
    , .rdata     (rdata)
    , .rresp     (rresp)
    , .rlast     (rlast)
    , .mem_rdata (mem_rdata)
    , .mem_we    (mem_we)
    , .mem_be    (mem_be)
    , .mem_addr  (mem_addr)
    , .mem_wdata (mem_wdata)
    );

  gobou_weight_mem gobou_weight_mem_inst
    ( .clk   (clk)
    , .we    (mem_we)
    , .be    (mem_be)
    , .addr  (mem_addr)
    , .wdata (mem_wdata)
    , .rdata (mem_rdata)
    );

endmodule

// ==== source/ninjin_s_axi_gobou.sv ====
`timescale 1ns/1ps

module ninjin_s_axi_gobou
  ( input  logic                                  clk
  , input  logic                                  xrst
  // write address
  , input  logic [ninjin_pkg::ID_WIDTH-1:0]       awid
  , input  logic [ninjin_pkg::ADDR_WIDTH-1:0]     awaddr
  , input  logic [7:0]                            awlen
  , input  logic [1:0]                            awburst
  , input  logic                                  awvalid
  , output logic                                  awready
  // write data
  , input  logic [ninjin_pkg::DATA_WIDTH-1:0]     wdata
  , input  logic [ninjin_pkg::DATA_WIDTH/8-1:0]   wstrb
  , input  logic                                  wlast
  , input  logic                                  wvalid
  , output logic                                  wready
  // write response
  , input  logic                                  bready
  , output logic                                  bvalid
  , output logic [ninjin_pkg::ID_WIDTH-1:0]       bid
  , output logic [1:0]                            bresp
  // read address
  , input  logic [ninjin_pkg::ID_WIDTH-1:0]       arid
  , input  logic [ninjin_pkg::ADDR_WIDTH-1:0]     araddr
  , input  logic [7:0]                            arlen
  , input  logic [1:0]                            arburst
  , input  logic                                  arvalid
  , output logic                                  arready
  // read data
  , input  logic                                  rready
  , output logic                                  rvalid
  , output logic [ninjin_pkg::ID_WIDTH-1:0]       rid
  , output logic [ninjin_pkg::DATA_WIDTH-1:0]     rdata
  , output logic [1:0]                            rresp
  , output logic                                  rlast
  // weight memory
  , input  logic [ninjin_pkg::DATA_WIDTH-1:0]     mem_rdata
  , output logic                                  mem_we
  , output logic [ninjin_pkg::DATA_WIDTH/8-1:0]   mem_be
  , output logic [ninjin_pkg::MEM_ADDR_WIDTH-1:0] mem_addr
  , output logic [ninjin_pkg::DATA_WIDTH-1:0]     mem_wdata
  );
  import ninjin_pkg::*;

  logic                  wr_busy;
  logic                  rd_busy;
  logic                  idle;
  logic                  aw_start;
  logic                  ar_start;
  logic                  wr_beat;
  logic                  rd_beat;
  logic                  wr_done;
  logic                  wr_last;
  logic                  rd_last;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] rd_addr;

//==================================================
// channel state
//==================================================

  assign idle = !wr_busy && !rd_busy;

  // a new write waits for the previous response to leave, so bid stays put
  assign aw_start = idle && awvalid && !bvalid;
  // write wins a tie
  assign ar_start = idle && arvalid && !aw_start;

  assign wr_beat = wready && wvalid;
  assign rd_beat = rvalid && rready;

  // close on wlast, or on the counted final beat
  assign wr_done = wr_beat && (wlast || wr_last);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_busy <= 1'b0;
      rd_busy <= 1'b0;
    end else begin
      if (aw_start)
        wr_busy <= 1'b1;
      else if (wr_done)
        wr_busy <= 1'b0;

      if (ar_start)
        rd_busy <= 1'b1;
      else if (rd_beat && rd_last)
        rd_busy <= 1'b0;
    end
  end

  ninjin_burst_addr wr_addr_inst
    ( .clk        (clk)
    , .xrst       (xrst)
    , .start      (aw_start)
    , .step       (wr_beat)
    , .start_addr (awaddr)
    , .len        (awlen)
    , .burst      (awburst)
    , .addr       (wr_addr)
    , .last       (wr_last)
    );

  ninjin_burst_addr rd_addr_inst
    ( .clk        (clk)
    , .xrst       (xrst)
    , .start      (ar_start)
    , .step       (rd_beat)
    , .start_addr (araddr)
    , .len        (arlen)
    , .burst      (arburst)
    , .addr       (rd_addr)
    , .last       (rd_last)
    );

//==================================================
// handshakes
//==================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      awready <= 1'b0;
      arready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      // one-cycle pulses, busy blocks a second start
      awready <= aw_start;
      arready <= ar_start;

      if (wr_done)
        wready <= 1'b0;
      else if (wr_busy && wvalid && !wready)
        wready <= 1'b1;

      if (wr_done)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;

      // drop for a cycle after each accepted beat
      if (rd_beat)
        rvalid <= 1'b0;
      else if (rd_busy)
        rvalid <= 1'b1;
    end
  end

  // ids held for the whole transaction
  always_ff @(posedge clk) begin
    if (aw_start)
      bid <= awid;
    if (ar_start)
      rid <= arid;
  end

  assign bresp = RESP_OKAY;
  assign rresp = RESP_OKAY;
  assign rlast = rvalid && rd_last;

//==================================================
// memory port
//==================================================

  assign mem_we    = wr_beat;
  assign mem_be    = wstrb;
  assign mem_wdata = wdata;
  assign mem_addr  = rd_busy ? rd_addr[ADDR_WIDTH-1:LSB]
                   : wr_busy ? wr_addr[ADDR_WIDTH-1:LSB]
                   : '0;

  // read word follows mem_addr with no register
  assign rdata = mem_rdata;

endmodule

// ==== source/gobou_weight_mem.sv ====
`timescale 1ns/1ps

module gobou_weight_mem
  ( input  logic                                  clk
  , input  logic                                  we
  , input  logic [ninjin_pkg::DATA_WIDTH/8-1:0]   be
  , input  logic [ninjin_pkg::MEM_ADDR_WIDTH-1:0] addr
  , input  logic [ninjin_pkg::DATA_WIDTH-1:0]     wdata
  , output logic [ninjin_pkg::DATA_WIDTH-1:0]     rdata
  );
  import ninjin_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

  // byte lanes written independently
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < DATA_WIDTH/8; i++) begin
        if (be[i])
          mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  // asynchronous read
  assign rdata = mem[addr];

endmodule

// ==== source/ninjin_burst_addr.sv ====
`timescale 1ns/1ps

module ninjin_burst_addr
  ( input  logic                              clk
  , input  logic                              xrst
  , input  logic                              start
  , input  logic                              step
  , input  logic [ninjin_pkg::ADDR_WIDTH-1:0] start_addr
  , input  logic [7:0]                        len
  , input  logic [1:0]                        burst
  , output logic [ninjin_pkg::ADDR_WIDTH-1:0] addr
  , output logic                              last
  );
  import ninjin_pkg::*;

  logic [7:0]                len_r;
  logic [7:0]                cnt;
  logic [1:0]                burst_r;
  logic [ADDR_WIDTH-LSB-1:0] word;
  logic [ADDR_WIDTH-LSB-1:0] word_inc;
  logic [ADDR_WIDTH-LSB-1:0] wrap_mask;
  logic [ADDR_WIDTH-LSB-1:0] word_next;

  assign word      = addr[ADDR_WIDTH-1:LSB];
  assign word_inc  = word + 1'b1;
  // window of len+1 words, len+1 is a power of two for legal wraps
  assign wrap_mask = {{(ADDR_WIDTH-LSB-8){1'b0}}, len_r};

  always_comb begin
    case (burst_r)
      BURST_INCR: word_next = word_inc;
      // low bits count up and roll over, high bits hold the window base
      BURST_WRAP: word_next = (word & ~wrap_mask) | (word_inc & wrap_mask);
      default:    word_next = word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      len_r   <= '0;
      burst_r <= BURST_FIXED;
      cnt     <= '0;
    end else if (start) begin
      len_r   <= len;
      burst_r <= burst;
      cnt     <= '0;
    end else if (step) begin
      cnt <= cnt + 1'b1;
    end
  end

  // fixed bursts keep the byte offset too
  always_ff @(posedge clk) begin
    if (start)
      addr <= start_addr;
    else if (step && burst_r != BURST_FIXED)
      addr <= {word_next, {LSB{1'b0}}};
  end

  assign last = (cnt == len_r);

endmodule

// ==== source/ninjin_pkg.sv ====
package ninjin_pkg;

  // ==================================================
  // bus geometry
  // ==================================================

  // AXI data word and memory word
  localparam int DATA_WIDTH = 32;

  // byte address seen on awaddr / araddr
  localparam int ADDR_WIDTH = 12;

  // transaction id, echoed on bid / rid
  localparam int ID_WIDTH = 12;

  // byte offset bits inside one word
  localparam int LSB = 2;

  // ==================================================
  // weight memory
  // ==================================================

  localparam int MEM_WORDS = 1024;

  // word address, ADDR_WIDTH minus the byte offset
  localparam int MEM_ADDR_WIDTH = 10;

  // ==================================================
  // AXI encodings
  // ==================================================

  // burst types on awburst / arburst, code 3 is reserved
  localparam logic [1:0] BURST_FIXED = 2'd0;
  localparam logic [1:0] BURST_INCR  = 2'd1;
  localparam logic [1:0] BURST_WRAP  = 2'd2;

  // only OKAY is ever returned
  localparam logic [1:0] RESP_OKAY   = 2'd0;

endpackage
